/* la32_decode.f */
+incdir+sim
verilog/la32_decode_pkg.sv
verilog/la32_op_decoder.sv
verilog/la32_operand_decoder.sv
verilog/la32_uop_register.sv
verilog/la32_decode_top.sv
sim/la32_decode_tb.sv

/* Bender.yml */
package:
  name: la32_decode

sources:
  - verilog/la32_decode_pkg.sv
  - verilog/la32_op_decoder.sv
  - verilog/la32_operand_decoder.sv
  - verilog/la32_uop_register.sv
  - verilog/la32_decode_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/la32_decode_tb.sv

/* sim/la32_decode_model.svh */
/* Reference decode of LA32R words, built from the ISA opcode tables.
   Must be included inside a module that imports la32_decode_pkg. */
`ifndef LA32_DECODE_MODEL_SVH
`define LA32_DECODE_MODEL_SVH

//////////////////////////////////////////////////
// instruction kinds
//////////////////////////////////////////////////
localparam int KIND_BAD     = 0;
localparam int KIND_ALU3    = 1;
// slti, sltui, addi
localparam int KIND_ALUI    = 2;
// andi, ori, xori
localparam int KIND_LOGI    = 3;
localparam int KIND_SHI     = 4;
localparam int KIND_LUI     = 5;
localparam int KIND_PCADD   = 6;
localparam int KIND_LOAD    = 7;
localparam int KIND_STORE   = 8;
localparam int KIND_JIRL    = 9;
localparam int KIND_B       = 10;
localparam int KIND_BL      = 11;
localparam int KIND_BCC     = 12;
localparam int KIND_MUL     = 13;
localparam int KIND_DIV     = 14;
localparam int KIND_SYSCALL = 15;
localparam int KIND_BREAK   = 16;

function automatic int inst_kind(inst_t w);
    // 17-bit opcodes, three-register and shift forms
    case (w[31:15])
        17'h00020, 17'h00022, 17'h00024, 17'h00025, 17'h00028, 17'h00029,
        17'h0002a, 17'h0002b, 17'h0002e, 17'h0002f, 17'h00030: return KIND_ALU3;
        17'h00038, 17'h00039, 17'h0003a: return KIND_MUL;
        17'h00040, 17'h00041, 17'h00042, 17'h00043: return KIND_DIV;
        17'h00054: return KIND_BREAK;
        17'h00056: return KIND_SYSCALL;
        17'h00081, 17'h00089, 17'h00091: return KIND_SHI;
        default: ;
    endcase
    // 10-bit opcodes, 12-bit immediate forms
    case (w[31:22])
        10'h008, 10'h009, 10'h00a: return KIND_ALUI;
        10'h00d, 10'h00e, 10'h00f: return KIND_LOGI;
        10'h0a0, 10'h0a1, 10'h0a2, 10'h0a8, 10'h0a9: return KIND_LOAD;
        10'h0a4, 10'h0a5, 10'h0a6: return KIND_STORE;
        default: ;
    endcase
    if (w[31:25] == 7'h0a)
        return KIND_LUI;
    if (w[31:25] == 7'h0e)
        return KIND_PCADD;
    case (w[31:26])
        6'h13: return KIND_JIRL;
        6'h14: return KIND_B;
        6'h15: return KIND_BL;
        6'h16, 6'h17, 6'h18, 6'h19, 6'h1a, 6'h1b: return KIND_BCC;
        default: return KIND_BAD;
    endcase
endfunction

function automatic itype_t expected_itype(inst_t w);
    itype_t t;
    t = '0;
    if (w == INST_NOP)
        return t;
    case (inst_kind(w))
        KIND_ALU3, KIND_ALUI, KIND_LOGI, KIND_SHI, KIND_LUI, KIND_PCADD: t[ITYPE_ALU] = 1'b1;
        KIND_LOAD, KIND_STORE: t[ITYPE_MEM] = 1'b1;
        KIND_JIRL, KIND_B, KIND_BL, KIND_BCC: t[ITYPE_BR] = 1'b1;
        KIND_MUL: t[ITYPE_MUL] = 1'b1;
        KIND_DIV: t[ITYPE_DIV] = 1'b1;
        default: ;
    endcase
    return t;
endfunction

// invalid words give zero
function automatic op_t expected_op(inst_t w);
    case (inst_kind(w))
        KIND_ALU3: return (w[31:15] == 17'h00030) ? ALU_SRA : w[18:15];
        KIND_ALUI: return (w[23:22] == 2'b00) ? ALU_SLT : (w[23:22] == 2'b01) ? ALU_SLTU : ALU_ADD;
        KIND_LOGI: return (w[23:22] == 2'b01) ? ALU_AND : (w[23:22] == 2'b10) ? ALU_OR : ALU_XOR;
        KIND_SHI: return (w[19:18] == 2'b00) ? ALU_SLL : (w[19:18] == 2'b01) ? ALU_SRL : ALU_SRA;
        KIND_LUI, KIND_PCADD: return ALU_ADD;
        KIND_LOAD, KIND_STORE: return {1'b0, w[24], w[23:22]};
        KIND_JIRL, KIND_B, KIND_BL, KIND_BCC: return w[29:26];
        // high half of a product, remainder of a division
        KIND_MUL: return (w[16:15] == 2'b00) ? 4'd0 : 4'd1;
        KIND_DIV: return {3'b000, w[15]};
        default: return '0;
    endcase
endfunction

function automatic logic expected_sign(inst_t w);
    case (inst_kind(w))
        KIND_MUL, KIND_DIV: return !w[16];
        KIND_LOAD, KIND_STORE: return !w[25];
        default: return 1'b0;
    endcase
endfunction

function automatic reg_idx_t expected_rd(inst_t w);
    case (inst_kind(w))
        KIND_STORE, KIND_BCC, KIND_B: return '0;
        KIND_BL: return 5'd1;
        default: return w[4:0];
    endcase
endfunction

function automatic reg_idx_t expected_rj(inst_t w);
    case (inst_kind(w))
        KIND_B, KIND_BL, KIND_LUI, KIND_PCADD: return '0;
        default: return w[9:5];
    endcase
endfunction

function automatic reg_idx_t expected_rk(inst_t w);
    case (inst_kind(w))
        KIND_ALU3, KIND_MUL, KIND_DIV: return w[14:10];
        KIND_STORE, KIND_BCC: return w[4:0];
        default: return '0;
    endcase
endfunction

function automatic imm_t expected_imm(inst_t w);
    case (inst_kind(w))
        KIND_ALUI, KIND_SHI, KIND_LOAD, KIND_STORE: return {{20{w[21]}}, w[21:10]};
        KIND_LOGI: return {20'b0, w[21:10]};
        KIND_JIRL, KIND_BCC: return {{16{w[25]}}, w[25:10]};
        // offs26 keeps its high part in the low bits of the word
        KIND_B, KIND_BL: return {{6{w[9]}}, w[9:0], w[25:10]};
        KIND_LUI, KIND_PCADD: return {w[24:5], 12'b0};
        default: return '0;
    endcase
endfunction

function automatic src1_t expected_src1(inst_t w);
    case (inst_kind(w))
        KIND_LUI: return SRC1_ZERO;
        KIND_PCADD: return SRC1_PC;
        default: return SRC1_RF;
    endcase
endfunction

function automatic src2_t expected_src2(inst_t w);
    case (inst_kind(w))
        KIND_ALUI, KIND_LOGI, KIND_SHI, KIND_LUI, KIND_PCADD: return SRC2_IMM;
        default: return SRC2_RF;
    endcase
endfunction

`endif

/* sim/la32_decode_tb.sv */
/* Random test of the LA32R decode stage against a reference model, HOLD_ON_INVALID = 0.
   Register, immediate and source fields are checked only for valid words. */
`timescale 1ns/10ps
`default_nettype none

module la32_decode_tb;
    import la32_decode_pkg::*;

    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 3;
    localparam int NUM_VECTORS  = 5000;
    localparam int TIME_LIMIT   = (RESET_CYCLES + NUM_VECTORS) * CLK_PERIOD + 50 * CLK_PERIOD;

    logic     clk;
    logic     rst;
    logic     stall;
    logic     flush;
    logic     in_valid;
    inst_t    in_inst;
    addr_t    in_pc;
    addr_t    in_pc_next;
    exc_t     in_exc;
    addr_t    in_badv;
    logic     out_valid;
    addr_t    out_pc;
    addr_t    out_pc_next;
    exc_t     out_exc;
    addr_t    out_badv;
    itype_t   out_itype;
    op_t      out_op;
    logic     out_sign;
    reg_idx_t out_rd;
    reg_idx_t out_rj;
    reg_idx_t out_rk;
    imm_t     out_imm;
    src1_t    out_src1;
    src2_t    out_src2;
    logic     out_invalid;
    logic     out_syscall;
    logic     out_break;

    // expected contents of the uop register
    logic     exp_valid;
    logic     exp_invalid;
    logic     exp_syscall;
    logic     exp_break;
    addr_t    exp_pc;
    addr_t    exp_pc_next;
    exc_t     exp_exc;
    addr_t    exp_badv;
    itype_t   exp_itype;
    op_t      exp_op;
    logic     exp_sign;
    reg_idx_t exp_rd;
    reg_idx_t exp_rj;
    reg_idx_t exp_rk;
    imm_t     exp_imm;
    src1_t    exp_src1;
    src2_t    exp_src2;
    int       exp_kind;
    // payload has no reset, so it means nothing before the first load
    logic     loaded;
    integer   seed;

    `include "la32_decode_model.svh"

    la32_decode_top #(
        .HOLD_ON_INVALID (1'b0)
    ) uut (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .flush       (flush),
        .in_valid    (in_valid),
        .in_inst     (in_inst),
        .in_pc       (in_pc),
        .in_pc_next  (in_pc_next),
        .in_exc      (in_exc),
        .in_badv     (in_badv),
        .out_valid   (out_valid),
        .out_pc      (out_pc),
        .out_pc_next (out_pc_next),
        .out_exc     (out_exc),
        .out_badv    (out_badv),
        .out_itype   (out_itype),
        .out_op      (out_op),
        .out_sign    (out_sign),
        .out_rd      (out_rd),
        .out_rj      (out_rj),
        .out_rk      (out_rk),
        .out_imm     (out_imm),
        .out_src1    (out_src1),
        .out_src2    (out_src2),
        .out_invalid (out_invalid),
        .out_syscall (out_syscall),
        .out_break   (out_break)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    initial begin
        #(TIME_LIMIT);
        $display("watchdog expired at %0t ns before all vectors were run", $time);
        $display("TEST FAILED");
        $fatal(1, "watchdog timeout");
    end

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////
    task automatic fail_now(input string msg);
        $display("[ERROR] %0t ns: %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1, "decode mismatch");
    endtask

    task automatic check_flags(input logic valid, input logic invalid,
                               input logic syscall, input logic brk);
        if (valid !== exp_valid)
            fail_now($sformatf("out_valid %b, expected %b", valid, exp_valid));
        if (invalid !== exp_invalid)
            fail_now($sformatf("out_invalid %b, expected %b", invalid, exp_invalid));
        if (syscall !== exp_syscall)
            fail_now($sformatf("out_syscall %b, expected %b", syscall, exp_syscall));
        if (brk !== exp_break)
            fail_now($sformatf("out_break %b, expected %b", brk, exp_break));
    endtask

    task automatic check_meta(input addr_t pc, input addr_t pc_next,
                              input exc_t exc, input addr_t badv);
        if (pc !== exp_pc)
            fail_now($sformatf("out_pc %h, expected %h", pc, exp_pc));
        if (pc_next !== exp_pc_next)
            fail_now($sformatf("out_pc_next %h, expected %h", pc_next, exp_pc_next));
        if (exc !== exp_exc)
            fail_now($sformatf("out_exc %h, expected %h", exc, exp_exc));
        if (badv !== exp_badv)
            fail_now($sformatf("out_badv %h, expected %h", badv, exp_badv));
    endtask

    task automatic check_uop(input itype_t itype, input op_t op, input logic sign,
                             input reg_idx_t rd, input reg_idx_t rj, input reg_idx_t rk,
                             input imm_t imm, input src1_t src1, input src2_t src2);
        if (itype !== exp_itype)
            fail_now($sformatf("out_itype %b, expected %b", itype, exp_itype));
        if (op !== exp_op)
            fail_now($sformatf("out_op %h, expected %h", op, exp_op));
        if (exp_kind != KIND_BAD) begin
            if (sign !== exp_sign)
                fail_now($sformatf("out_sign %b, expected %b", sign, exp_sign));
            if (rd !== exp_rd || rj !== exp_rj || rk !== exp_rk)
                fail_now($sformatf("rd/rj/rk %0d/%0d/%0d, expected %0d/%0d/%0d",
                                   rd, rj, rk, exp_rd, exp_rj, exp_rk));
            if (imm !== exp_imm)
                fail_now($sformatf("out_imm %h, expected %h", imm, exp_imm));
            if (src1 !== exp_src1 || src2 !== exp_src2)
                fail_now($sformatf("src1/src2 %0d/%0d, expected %0d/%0d",
                                   src1, src2, exp_src1, exp_src2));
        end
    endtask

    //////////////////////////////////////////////////
    // scoreboard and stimulus
    //////////////////////////////////////////////////
    // same priority as the stage: reset, flush, stall, load
    task automatic advance_model;
        int   kind;
        logic exc_seen;
        kind     = inst_kind(in_inst);
        exc_seen = in_exc != '0;
        if (rst) begin
            exp_valid   = 1'b0;
            exp_invalid = 1'b0;
            exp_syscall = 1'b0;
            exp_break   = 1'b0;
        end else if (flush) begin
            exp_valid = 1'b0;
        end else if (!stall) begin
            exp_valid = in_valid;
            if (in_valid) begin
                loaded      = 1'b1;
                exp_kind    = kind;
                exp_pc      = in_pc;
                exp_pc_next = in_pc_next;
                exp_exc     = in_exc;
                exp_badv    = in_badv;
                exp_itype   = exc_seen ? '0 : expected_itype(in_inst);
                exp_op      = expected_op(in_inst);
                exp_sign    = expected_sign(in_inst);
                exp_rd      = expected_rd(in_inst);
                exp_rj      = expected_rj(in_inst);
                exp_rk      = expected_rk(in_inst);
                exp_imm     = expected_imm(in_inst);
                exp_src1    = expected_src1(in_inst);
                exp_src2    = expected_src2(in_inst);
                exp_invalid = (kind == KIND_BAD) && !exc_seen;
                exp_syscall = (kind == KIND_SYSCALL) && !exc_seen;
                exp_break   = (kind == KIND_BREAK) && !exc_seen;
            end
        end
    endtask

    // opcode template with random fields; subcode ranges include unassigned ones
    function automatic inst_t template_word(logic [3:0] family, logic [3:0] sub, inst_t fields);
        case (family)
            4'd0: return {13'h0002, sub, fields[14:0]};
            4'd1: return {15'h000e, sub[1:0], fields[14:0]};
            4'd2: return {15'h0010, sub[1:0], fields[14:0]};
            4'd3: return {12'h004, sub[1:0], 3'b001, fields[14:0]};
            4'd4: return {7'h01, sub[2:0], fields[21:0]};
            4'd5: return {6'h0a, sub, fields[21:0]};
            // lu12i.w or pcaddu12i
            4'd6: return {4'b0001, sub[0], 2'b10, fields[24:0]};
            4'd7: return {2'b01, sub, fields[25:0]};
            4'd8: begin
                case (sub[1:0])
                    2'd0: return {17'h00030, fields[14:0]};
                    2'd1: return {17'h00056, fields[14:0]};
                    2'd2: return {17'h00054, fields[14:0]};
                    default: return INST_NOP;
                endcase
            end
            default: return fields;
        endcase
    endfunction

    task automatic drive_inputs;
        logic [31:0] r;
        inst_t       fields;
        r          = $random(seed);
        fields     = $random(seed);
        in_valid   = r[1:0] != 2'b00;
        stall      = r[4:2] == 3'b000;
        flush      = r[7:5] == 3'b000;
        in_inst    = template_word(r[11:8] % 4'd10, r[15:12], fields);
        in_exc     = (r[19:16] == 4'h0) ? (r[26:20] | 7'h01) : 7'h00;
        in_pc      = $random(seed);
        in_pc[1:0] = 2'b00;
        in_pc_next = in_pc + 32'd4;
        in_badv    = $random(seed);
    endtask

    initial begin
        int cycle;
        seed        = 75;
        rst         = 1'b1;
        stall       = 1'b0;
        flush       = 1'b0;
        in_valid    = 1'b0;
        in_inst     = INST_NOP;
        in_pc       = '0;
        in_pc_next  = '0;
        in_exc      = '0;
        in_badv     = '0;
        loaded      = 1'b0;
        exp_kind    = KIND_BAD;
        exp_valid   = 1'b0;
        exp_invalid = 1'b0;
        exp_syscall = 1'b0;
        exp_break   = 1'b0;
        for (cycle = 0; cycle < RESET_CYCLES + NUM_VECTORS; cycle++) begin
            @(posedge clk);
            advance_model();
            #1;
            check_flags(out_valid, out_invalid, out_syscall, out_break);
            if (loaded) begin
                check_meta(out_pc, out_pc_next, out_exc, out_badv);
                check_uop(out_itype, out_op, out_sign, out_rd, out_rj, out_rk,
                          out_imm, out_src1, out_src2);
            end
            #1;
            // reset drops after the third edge
            if (cycle >= RESET_CYCLES - 1) begin
                rst = 1'b0;
                drive_inputs();
            end
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/la32_decode_top.sv */
/* LA32R decode stage with one cycle of latency.
   HOLD_ON_INVALID = 0 zeroes class and op of invalid words. */
`timescale 1ns/10ps
`default_nettype none

module la32_decode_top #(
    parameter bit HOLD_ON_INVALID = 1'b1
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      stall,
    input  logic                      flush,
    input  logic                      in_valid,
    input  la32_decode_pkg::inst_t    in_inst,
    input  la32_decode_pkg::addr_t    in_pc,
    input  la32_decode_pkg::addr_t    in_pc_next,
    input  la32_decode_pkg::exc_t     in_exc,
    input  la32_decode_pkg::addr_t    in_badv,
    output logic                      out_valid,
    output la32_decode_pkg::addr_t    out_pc,
    output la32_decode_pkg::addr_t    out_pc_next,
    output la32_decode_pkg::exc_t     out_exc,
    output la32_decode_pkg::addr_t    out_badv,
    output la32_decode_pkg::itype_t   out_itype,
    output la32_decode_pkg::op_t      out_op,
    output logic                      out_sign,
    output la32_decode_pkg::reg_idx_t out_rd,
    output la32_decode_pkg::reg_idx_t out_rj,
    output la32_decode_pkg::reg_idx_t out_rk,
    output la32_decode_pkg::imm_t     out_imm,
    output la32_decode_pkg::src1_t    out_src1,
    output la32_decode_pkg::src2_t    out_src2,
    output logic                      out_invalid,
    output logic                      out_syscall,
    output logic                      out_break
);
    import la32_decode_pkg::*;

    itype_t   itype;
    op_t      op;
    logic     sign;
    logic     is_syscall;
    logic     is_break;
    logic     op_invalid;
    reg_idx_t rd;
    reg_idx_t rj;
    reg_idx_t rk;
    imm_t     imm;
    src1_t    src1;
    src2_t    src2;

    //////////////////////////////////////////////////
    // both decoders see the same word
    //////////////////////////////////////////////////
    la32_op_decoder u_op_dec (
        .inst       (in_inst),
        .itype      (itype),
        .op         (op),
        .sign       (sign),
        .is_syscall (is_syscall),
        .is_break   (is_break),
        .op_invalid (op_invalid)
    );

    la32_operand_decoder u_opnd_dec (
        .inst (in_inst),
        .rd   (rd),
        .rj   (rj),
        .rk   (rk),
        .imm  (imm),
        .src1 (src1),
        .src2 (src2)
    );

    la32_uop_register #(
        .HOLD_ON_INVALID (HOLD_ON_INVALID)
    ) u_uop_reg (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .flush       (flush),
        .in_valid    (in_valid),
        .in_pc       (in_pc),
        .in_pc_next  (in_pc_next),
        .in_exc      (in_exc),
        .in_badv     (in_badv),
        .itype       (itype),
        .op          (op),
        .sign        (sign),
        .is_syscall  (is_syscall),
        .is_break    (is_break),
        .op_invalid  (op_invalid),
        .rd          (rd),
        .rj          (rj),
        .rk          (rk),
        .imm         (imm),
        .src1        (src1),
        .src2        (src2),
        .out_valid   (out_valid),
        .out_pc      (out_pc),
        .out_pc_next (out_pc_next),
        .out_exc     (out_exc),
        .out_badv    (out_badv),
        .out_itype   (out_itype),
        .out_op      (out_op),
        .out_sign    (out_sign),
        .out_rd      (out_rd),
        .out_rj      (out_rj),
        .out_rk      (out_rk),
        .out_imm     (out_imm),
        .out_src1    (out_src1),
        .out_src2    (out_src2),
        .out_invalid (out_invalid),
        .out_syscall (out_syscall),
        .out_break   (out_break)
    );

endmodule

`default_nettype wire

/* verilog/la32_uop_register.sv */
/* Output register of the decode stage.
   flush beats stall, stall beats load; a cycle without in_valid leaves a bubble.
   A nonzero fetch exception clears the class and the invalid, syscall and break flags. */
`timescale 1ns/10ps
`default_nettype none

module la32_uop_register #(
    parameter bit HOLD_ON_INVALID = 1'b1
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      stall,
    input  logic                      flush,
    input  logic                      in_valid,
    input  la32_decode_pkg::addr_t    in_pc,
    input  la32_decode_pkg::addr_t    in_pc_next,
    input  la32_decode_pkg::exc_t     in_exc,
    input  la32_decode_pkg::addr_t    in_badv,
    input  la32_decode_pkg::itype_t   itype,
    input  la32_decode_pkg::op_t      op,
    input  logic                      sign,
    input  logic                      is_syscall,
    input  logic                      is_break,
    input  logic                      op_invalid,
    input  la32_decode_pkg::reg_idx_t rd,
    input  la32_decode_pkg::reg_idx_t rj,
    input  la32_decode_pkg::reg_idx_t rk,
    input  la32_decode_pkg::imm_t     imm,
    input  la32_decode_pkg::src1_t    src1,
    input  la32_decode_pkg::src2_t    src2,
    output logic                      out_valid,
    output la32_decode_pkg::addr_t    out_pc,
    output la32_decode_pkg::addr_t    out_pc_next,
    output la32_decode_pkg::exc_t     out_exc,
    output la32_decode_pkg::addr_t    out_badv,
    output la32_decode_pkg::itype_t   out_itype,
    output la32_decode_pkg::op_t      out_op,
    output logic                      out_sign,
    output la32_decode_pkg::reg_idx_t out_rd,
    output la32_decode_pkg::reg_idx_t out_rj,
    output la32_decode_pkg::reg_idx_t out_rk,
    output la32_decode_pkg::imm_t     out_imm,
    output la32_decode_pkg::src1_t    out_src1,
    output la32_decode_pkg::src2_t    out_src2,
    output logic                      out_invalid,
    output logic                      out_syscall,
    output logic                      out_break
);
    import la32_decode_pkg::*;

    wire take      = in_valid && !stall && !flush;
    // instruction from a faulting fetch is not trusted
    wire fetch_exc = in_exc != '0;
    wire drop_ops  = op_invalid && !HOLD_ON_INVALID;

    //////////////////////////////////////////////////
    // control state
    //////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid   <= 1'b0;
            out_invalid <= 1'b0;
            out_syscall <= 1'b0;
            out_break   <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;
        end else if (!stall) begin
            out_valid <= in_valid;
            if (in_valid) begin
                out_invalid <= op_invalid && !fetch_exc;
                out_syscall <= is_syscall && !fetch_exc;
                out_break   <= is_break && !fetch_exc;
            end
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (take) begin
            out_pc      <= in_pc;
            out_pc_next <= in_pc_next;
            out_exc     <= in_exc;
            out_badv    <= in_badv;
            out_itype   <= (fetch_exc || drop_ops) ? itype_t'('0) : itype;
            out_op      <= drop_ops ? op_t'('0) : op;
            out_sign    <= sign;
            out_rd      <= rd;
            out_rj      <= rj;
            out_rk      <= rk;
            out_imm     <= imm;
            out_src1    <= src1;
            out_src2    <= src2;
        end
    end

    no_syscall_and_break: assert property (
        @(posedge clk) disable iff (rst) !(out_syscall && out_break)
    ) else $error("uop register: syscall and break flagged together");

endmodule

`default_nettype wire

/* verilog/la32_operand_decoder.sv */
/* Register indices, immediate and operand sources from the instruction word alone.
   Stores and conditional branches read their data register through rk, with rd zero.
   Shift immediates use the i12 form, so the ALU takes only imm[4:0]. */
`timescale 1ns/10ps
`default_nettype none

module la32_operand_decoder (
    input  la32_decode_pkg::inst_t    inst,
    output la32_decode_pkg::reg_idx_t rd,
    output la32_decode_pkg::reg_idx_t rj,
    output la32_decode_pkg::reg_idx_t rk,
    output la32_decode_pkg::imm_t     imm,
    output la32_decode_pkg::src1_t    src1,
    output la32_decode_pkg::src2_t    src2
);
    import la32_decode_pkg::*;

    localparam reg_idx_t REG_RA = 5'd1;

    wire is_alu3     = inst[30:19] == 12'b0000_0000_0010;
    wire is_sra      = inst[30:15] == 16'b0000_0000_0011_0000;
    wire is_alu_imm  = inst[30:25] == 6'b000001;
    wire is_alu_sfti = (inst[30:20] == 11'b000_0000_0100) && (inst[17:15] == 3'b001);
    wire is_lui      = inst[30:25] == 6'b001010;
    wire is_pcadd    = inst[30:25] == 6'b001110;
    wire is_mem      = inst[30:26] == 5'b01010;
    wire is_st       = is_mem && inst[24];
    wire is_muldiv   = (inst[30:18] == 13'b0_0000_0000_0111) ||
                       (inst[30:17] == 14'b00_0000_0001_0000);
    wire is_jirl     = inst[30:26] == 5'b10011;
    wire is_b        = inst[30:26] == 5'b10100;
    wire is_bl       = inst[30:26] == 5'b10101;
    // beq up to bgeu
    wire is_bcc      = inst[30] && (inst[29:26] >= 4'd6) && (inst[29:26] <= 4'd11);

    //////////////////////////////////////////////////
    // register indices
    //////////////////////////////////////////////////
    always_comb begin
        if (is_st || is_bcc || is_b) begin
            rd = '0;
        end else if (is_bl) begin
            rd = REG_RA;
        end else begin
            rd = inst[4:0];
        end
    end

    assign rj = (is_b || is_bl || is_lui || is_pcadd) ? '0 : inst[9:5];

    assign rk = (is_alu3 || is_sra || is_muldiv) ? inst[14:10] :
                (is_st || is_bcc)                ? inst[4:0]   : '0;

    //////////////////////////////////////////////////
    // immediate
    //////////////////////////////////////////////////
    // andi/ori/xori have inst[24] set, slti/sltui/addi clear
    always_comb begin
        if ((is_alu_imm && !inst[24]) || is_alu_sfti || is_mem) begin
            imm = {{20{inst[21]}}, inst[21:10]};
        end else if (is_alu_imm) begin
            imm = {20'b0, inst[21:10]};
        end else if (is_bcc || is_jirl) begin
            imm = {{16{inst[25]}}, inst[25:10]};
        end else if (is_b || is_bl) begin
            imm = {{6{inst[9]}}, inst[9:0], inst[25:10]};
        end else if (is_lui || is_pcadd) begin
            imm = {inst[24:5], 12'b0};
        end else begin
            imm = '0;
        end
    end

    //////////////////////////////////////////////////
    // operand sources
    //////////////////////////////////////////////////
    assign src1 = is_lui   ? SRC1_ZERO :
                  is_pcadd ? SRC1_PC   : SRC1_RF;

    // memory address adds imm in its own unit
    assign src2 = (is_alu_imm || is_alu_sfti || is_lui || is_pcadd) ? SRC2_IMM : SRC2_RF;

endmodule

`default_nettype wire

/* verilog/la32_op_decoder.sv */
/* Combinational class and operation decode for LA32R.
   Invalid subcodes keep their class here; the uop register decides whether to clear it.
   Only the nop word gives an all-zero class for a valid instruction besides syscall/break. */
`timescale 1ns/10ps
`default_nettype none

module la32_op_decoder (
    input  la32_decode_pkg::inst_t  inst,
    output la32_decode_pkg::itype_t itype,
    output la32_decode_pkg::op_t    op,
    output logic                    sign,
    output logic                    is_syscall,
    output logic                    is_break,
    output logic                    op_invalid
);
    import la32_decode_pkg::*;

    //////////////////////////////////////////////////
    // opcode families
    //////////////////////////////////////////////////
    wire is_alu3     = inst[30:19] == 12'b0000_0000_0010;
    wire is_sra      = inst[30:15] == 16'b0000_0000_0011_0000;
    wire is_alu_imm  = inst[30:25] == 6'b000001;
    wire is_alu_sfti = (inst[30:20] == 11'b000_0000_0100) && (inst[17:15] == 3'b001);
    wire is_lui      = inst[30:25] == 6'b001010;
    wire is_pcadd    = inst[30:25] == 6'b001110;
    wire is_mem      = inst[30:26] == 5'b01010;
    wire is_br       = inst[30];
    wire is_mul      = inst[30:17] == 14'b00_0000_0000_1110;
    wire is_div      = inst[30:17] == 14'b00_0000_0001_0000;
    // syscall has inst[16] set, break has it clear
    wire is_ecall    = (inst[30:17] == 14'b00_0000_0001_0101) && !inst[15];

    itype_t cls;
    logic   sub_bad;

    assign cls[ITYPE_ALU] = is_alu3 | is_sra | is_alu_imm | is_alu_sfti | is_lui | is_pcadd;
    assign cls[ITYPE_MEM] = is_mem;
    assign cls[ITYPE_BR]  = is_br;
    assign cls[ITYPE_MUL] = is_mul;
    assign cls[ITYPE_DIV] = is_div;

    //////////////////////////////////////////////////
    // operation field and subcode check
    //////////////////////////////////////////////////
    always_comb begin
        op      = ALU_ADD;
        sub_bad = 1'b0;
        if (is_alu3) begin
            case (inst[18:15])
                ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
                ALU_NOR, ALU_AND, ALU_OR, ALU_XOR,
                ALU_SLL, ALU_SRL: op = inst[18:15];
                // add.d, sub.d, maskeqz and friends
                default: sub_bad = 1'b1;
            endcase
        end else if (is_sra) begin
            op = ALU_SRA;
        end else if (is_alu_imm) begin
            case (inst[24:22])
                3'b000:  op = ALU_SLT;
                3'b001:  op = ALU_SLTU;
                3'b010:  op = ALU_ADD;
                3'b101:  op = ALU_AND;
                3'b110:  op = ALU_OR;
                3'b111:  op = ALU_XOR;
                default: sub_bad = 1'b1;
            endcase
        end else if (is_alu_sfti) begin
            case (inst[19:18])
                2'b00:   op = ALU_SLL;
                2'b01:   op = ALU_SRL;
                2'b10:   op = ALU_SRA;
                default: sub_bad = 1'b1;
            endcase
        end else if (is_mem) begin
            op = {1'b0, inst[24], inst[23:22]};
            // no size 3, no unsigned store, no ld.wu
            sub_bad = (inst[23:22] == 2'b11) || (inst[25] && (inst[24] || inst[23]));
        end else if (is_br) begin
            op = inst[29:26];
            // jirl (0011) up to bgeu (1011)
            sub_bad = (inst[29:26] < 4'd3) || (inst[29:26] > 4'd11);
        end else if (is_mul) begin
            // op 1 is the high half
            op = {3'b000, inst[16] | inst[15]};
            sub_bad = inst[16] & inst[15];
        end else if (is_div) begin
            // op 1 is the remainder
            op = {3'b000, inst[15]};
        end
    end

    assign sign = ((is_mul | is_div) & ~inst[16]) | (is_mem & ~inst[25]);

    assign op_invalid = inst[31] | sub_bad | ((cls == '0) & ~is_ecall);
    assign is_syscall = is_ecall & inst[16] & ~inst[31];
    assign is_break   = is_ecall & ~inst[16] & ~inst[31];

    // nop gets its own all-zero class
    assign itype = (inst == INST_NOP) ? '0 : cls;

    always_comb begin
        itype_onehot: assert final ($onehot0(itype))
            else $error("op decoder: more than one class bit set");
    end

endmodule

`default_nettype wire

/* verilog/la32_decode_pkg.sv */
/* Types and codes shared by the LA32R decode stage.
   The meaning of op_t depends on the class (ALU op, branch condition or memory access).
   CSR, TLB, cache and atomic encodings have no codes here and decode as invalid. */
`default_nettype none

package la32_decode_pkg;

    //////////////////////////////////////////////////
    // widths that carry a meaning
    //////////////////////////////////////////////////
    typedef logic [31:0] inst_t;
    typedef logic [31:0] addr_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [31:0] imm_t;
    typedef logic [4:0]  itype_t;
    typedef logic [3:0]  op_t;
    typedef logic [6:0]  exc_t;
    typedef logic [1:0]  src1_t;
    typedef logic [1:0]  src2_t;

    //////////////////////////////////////////////////
    // class bit positions in itype_t
    //////////////////////////////////////////////////
    // all zero means nop, syscall/break or invalid
    localparam int ITYPE_ALU = 0;
    localparam int ITYPE_MEM = 1;
    localparam int ITYPE_BR  = 2;
    localparam int ITYPE_MUL = 3;
    localparam int ITYPE_DIV = 4;

    //////////////////////////////////////////////////
    // ALU operation codes
    //////////////////////////////////////////////////
    // same as inst[18:15] of the three-register group
    localparam op_t ALU_ADD  = 4'b0000;
    localparam op_t ALU_SUB  = 4'b0010;
    localparam op_t ALU_SLT  = 4'b0100;
    localparam op_t ALU_SLTU = 4'b0101;
    localparam op_t ALU_NOR  = 4'b1000;
    localparam op_t ALU_AND  = 4'b1001;
    localparam op_t ALU_OR   = 4'b1010;
    localparam op_t ALU_XOR  = 4'b1011;
    localparam op_t ALU_SLL  = 4'b1110;
    localparam op_t ALU_SRL  = 4'b1111;
    // sra.w sits outside that group, so it takes a free slot
    localparam op_t ALU_SRA  = 4'b1100;

    // branch op is inst[29:26] as is
    // memory op is {0, store, size[1:0]}, with sign carried separately

    //////////////////////////////////////////////////
    // operand sources
    //////////////////////////////////////////////////
    localparam src1_t SRC1_RF   = 2'd0;
    localparam src1_t SRC1_PC   = 2'd1;
    localparam src1_t SRC1_ZERO = 2'd2;

    localparam src2_t SRC2_RF   = 2'd0;
    localparam src2_t SRC2_IMM  = 2'd1;

    // andi r0, r0, 0
    localparam inst_t INST_NOP = 32'h0340_0000;

endpackage

`default_nettype wire
